//--- verilog/gfx_dbuf_pkg.sv
`default_nettype none

package gfx_dbuf_pkg;

  // horizontal timing in clk cycles
  localparam int H_ACTIVE = 32;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 4;
  localparam int H_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical timing in lines
  localparam int V_ACTIVE = 12;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  typedef logic [5:0]  xcoord_t;
  typedef logic [4:0]  ycoord_t;
  // red, green, blue nibbles from the top down
  typedef logic [11:0] pixel_t;
  typedef logic [19:0] sram_addr_t;
  typedef logic [15:0] sram_data_t;
  typedef logic [2:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  localparam wb_addr_t REG_CTRL   = 3'd0;
  localparam wb_addr_t REG_STATUS = 3'd1;
  localparam wb_addr_t REG_COLOR  = 3'd2;
  localparam wb_addr_t REG_RECT_X = 3'd3;
  localparam wb_addr_t REG_RECT_Y = 3'd4;

  typedef enum logic {
    IDLE,
    RUN
  } fill_state_t;

  // row-major pixel address
  function automatic sram_addr_t pix_addr(input xcoord_t px, input ycoord_t py);
    return sram_addr_t'(py) * sram_addr_t'(H_ACTIVE) + sram_addr_t'(px);
  endfunction

endpackage

`default_nettype wire

//--- verilog/vga_timing.sv
`default_nettype none

module vga_timing (
  input  logic                  clk,
  input  logic                  rst_n,
  output gfx_dbuf_pkg::xcoord_t x,
  output gfx_dbuf_pkg::ycoord_t y,
  output logic                  active,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  frame_start
);

  logic line_end;
  logic frame_end;

  assign line_end  = (x == gfx_dbuf_pkg::H_TOTAL - 1);
  assign frame_end = (y == gfx_dbuf_pkg::V_TOTAL - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else begin
      if (line_end) begin
        x <= '0;
        if (frame_end) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign active = (x < gfx_dbuf_pkg::H_ACTIVE) && (y < gfx_dbuf_pkg::V_ACTIVE);

  // both pulses active high
  assign hsync = (x >= gfx_dbuf_pkg::H_SYNC_START) && (x < gfx_dbuf_pkg::H_SYNC_END);
  assign vsync = (y >= gfx_dbuf_pkg::V_SYNC_START) && (y < gfx_dbuf_pkg::V_SYNC_END);

  // first cycle of the vertical sync pulse
  assign frame_start = (y == gfx_dbuf_pkg::V_SYNC_START) && (x == 0);

  a_x_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    x < gfx_dbuf_pkg::H_TOTAL
  ) else $error("vga_timing: x out of range");

endmodule

`default_nettype wire

//--- verilog/scanout.sv
`default_nettype none

module scanout (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     active,
  input  logic                     hsync,
  input  logic                     vsync,
  input  gfx_dbuf_pkg::xcoord_t    x,
  input  gfx_dbuf_pkg::ycoord_t    y,
  output gfx_dbuf_pkg::sram_addr_t rd_addr,
  input  gfx_dbuf_pkg::sram_data_t rd_data,
  output logic [3:0]               vga_r,
  output logic [3:0]               vga_g,
  output logic [3:0]               vga_b,
  output logic                     vga_hsync,
  output logic                     vga_vsync,
  output logic                     vga_de
);

  gfx_dbuf_pkg::pixel_t pix;

  assign rd_addr = gfx_dbuf_pkg::pix_addr(x, y);

  // upper nibble of the word is not part of the pixel
  assign pix = rd_data[11:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_r     <= '0;
      vga_g     <= '0;
      vga_b     <= '0;
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
      vga_de    <= 1'b0;
    end else begin
      vga_hsync <= hsync;
      vga_vsync <= vsync;
      vga_de    <= active;
      if (active) begin
        vga_r <= pix[11:8];
        vga_g <= pix[7:4];
        vga_b <= pix[3:0];
      end else begin
        // blank outside the visible area
        vga_r <= '0;
        vga_g <= '0;
        vga_b <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/fill_engine.sv
`default_nettype none

module fill_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fill_start,
  input  gfx_dbuf_pkg::pixel_t     fill_color,
  input  gfx_dbuf_pkg::xcoord_t    x0,
  input  gfx_dbuf_pkg::xcoord_t    x1,
  input  gfx_dbuf_pkg::ycoord_t    y0,
  input  gfx_dbuf_pkg::ycoord_t    y1,
  output logic                     fill_busy,
  output logic                     wr_en,
  output gfx_dbuf_pkg::sram_addr_t wr_addr,
  output gfx_dbuf_pkg::sram_data_t wr_data
);

  gfx_dbuf_pkg::fill_state_t state;
  gfx_dbuf_pkg::xcoord_t     cx;
  gfx_dbuf_pkg::xcoord_t     rx0;
  gfx_dbuf_pkg::xcoord_t     rx1;
  gfx_dbuf_pkg::ycoord_t     cy;
  gfx_dbuf_pkg::ycoord_t     ry1;
  gfx_dbuf_pkg::pixel_t      color;
  gfx_dbuf_pkg::xcoord_t     ex1;
  gfx_dbuf_pkg::ycoord_t     ey1;
  logic                      rect_ok;

  // clip the far corner to the visible area
  assign ex1 = (x1 > gfx_dbuf_pkg::H_ACTIVE - 1) ?
               gfx_dbuf_pkg::xcoord_t'(gfx_dbuf_pkg::H_ACTIVE - 1) : x1;
  assign ey1 = (y1 > gfx_dbuf_pkg::V_ACTIVE - 1) ?
               gfx_dbuf_pkg::ycoord_t'(gfx_dbuf_pkg::V_ACTIVE - 1) : y1;
  assign rect_ok = (x0 <= ex1) && (y0 <= ey1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= gfx_dbuf_pkg::IDLE;
    end else begin
      case (state)
        gfx_dbuf_pkg::IDLE: begin
          if (fill_start && rect_ok) begin
            state <= gfx_dbuf_pkg::RUN;
          end
        end
        gfx_dbuf_pkg::RUN: begin
          if (cx == rx1 && cy == ry1) begin
            state <= gfx_dbuf_pkg::IDLE;
          end
        end
        default: state <= gfx_dbuf_pkg::IDLE;
      endcase
    end
  end

  // cursor and latched rectangle
  always_ff @(posedge clk) begin
    if (state == gfx_dbuf_pkg::IDLE) begin
      rx0   <= x0;
      rx1   <= ex1;
      ry1   <= ey1;
      color <= fill_color;
      cx    <= x0;
      cy    <= y0;
    end else if (cx == rx1) begin
      cx <= rx0;
      cy <= cy + 1'b1;
    end else begin
      cx <= cx + 1'b1;
    end
  end

  assign fill_busy = (state == gfx_dbuf_pkg::RUN);
  assign wr_en     = fill_busy;
  assign wr_addr   = gfx_dbuf_pkg::pix_addr(cx, cy);
  assign wr_data   = {4'b0000, color};

  a_wr_in_frame : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_addr < gfx_dbuf_pkg::H_ACTIVE * gfx_dbuf_pkg::V_ACTIVE
  ) else $error("fill_engine: write outside the frame");

endmodule

`default_nettype wire

//--- verilog/dbuf_regs.sv
`default_nettype none

module dbuf_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  gfx_dbuf_pkg::wb_addr_t wb_adr,
  input  gfx_dbuf_pkg::wb_data_t wb_dat_w,
  output gfx_dbuf_pkg::wb_data_t wb_dat_r,
  output logic                   wb_ack,
  input  logic                   fill_busy,
  input  logic                   frame_start,
  output logic                   fill_start,
  output gfx_dbuf_pkg::pixel_t   fill_color,
  output gfx_dbuf_pkg::xcoord_t  x0,
  output gfx_dbuf_pkg::xcoord_t  x1,
  output gfx_dbuf_pkg::ycoord_t  y0,
  output gfx_dbuf_pkg::ycoord_t  y1,
  output logic                   front_sel
);

  logic req;
  logic wr;
  logic swap_pending;
  logic do_swap;

  // new cycle only while no ack is out
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign wr      = req && wb_we;
  assign do_swap = frame_start && swap_pending && !fill_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack       <= 1'b0;
      fill_start   <= 1'b0;
      swap_pending <= 1'b0;
      front_sel    <= 1'b0;
    end else begin
      wb_ack     <= req;
      fill_start <= wr && (wb_adr == gfx_dbuf_pkg::REG_CTRL) && wb_dat_w[0];
      if (do_swap) begin
        front_sel    <= !front_sel;
        swap_pending <= 1'b0;
      end
      // a fresh request wins over the clear
      if (wr && (wb_adr == gfx_dbuf_pkg::REG_CTRL) && wb_dat_w[1]) begin
        swap_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      case (wb_adr)
        gfx_dbuf_pkg::REG_COLOR: fill_color <= wb_dat_w[11:0];
        gfx_dbuf_pkg::REG_RECT_X: begin
          x0 <= wb_dat_w[5:0];
          x1 <= wb_dat_w[13:8];
        end
        gfx_dbuf_pkg::REG_RECT_Y: begin
          y0 <= wb_dat_w[4:0];
          y1 <= wb_dat_w[12:8];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      case (wb_adr)
        gfx_dbuf_pkg::REG_STATUS: begin
          wb_dat_r <= gfx_dbuf_pkg::wb_data_t'({front_sel, swap_pending, fill_busy});
        end
        gfx_dbuf_pkg::REG_COLOR:  wb_dat_r <= gfx_dbuf_pkg::wb_data_t'(fill_color);
        gfx_dbuf_pkg::REG_RECT_X: begin
          wb_dat_r <= gfx_dbuf_pkg::wb_data_t'({2'b00, x1, 2'b00, x0});
        end
        gfx_dbuf_pkg::REG_RECT_Y: begin
          wb_dat_r <= gfx_dbuf_pkg::wb_data_t'({3'b000, y1, 3'b000, y0});
        end
        // ctrl and unmapped words
        default: wb_dat_r <= '0;
      endcase
    end
  end

  a_ack_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack
  ) else $error("dbuf_regs: ack held for two cycles");

endmodule

`default_nettype wire

//--- verilog/sram_mux.sv
`default_nettype none

module sram_mux (
  input  logic                     front_sel,
  input  logic                     wr_en,
  input  gfx_dbuf_pkg::sram_addr_t rd_addr,
  input  gfx_dbuf_pkg::sram_addr_t wr_addr,
  input  gfx_dbuf_pkg::sram_data_t wr_data,
  output gfx_dbuf_pkg::sram_data_t rd_data,
  output gfx_dbuf_pkg::sram_addr_t sram0_addr,
  output gfx_dbuf_pkg::sram_addr_t sram1_addr,
  inout  wire gfx_dbuf_pkg::sram_data_t sram0_data,
  inout  wire gfx_dbuf_pkg::sram_data_t sram1_data,
  output logic                     sram0_ce_n,
  output logic                     sram0_oe_n,
  output logic                     sram0_we_n,
  output logic                     sram1_ce_n,
  output logic                     sram1_oe_n,
  output logic                     sram1_we_n
);

  // front_sel 0 scans sram0 and draws into sram1
  assign sram0_addr = front_sel ? wr_addr : rd_addr;
  assign sram1_addr = front_sel ? rd_addr : wr_addr;

  // back chip only selected during a write
  assign sram0_ce_n = front_sel ? !wr_en : 1'b0;
  assign sram1_ce_n = front_sel ? 1'b0 : !wr_en;
  assign sram0_oe_n = front_sel;
  assign sram1_oe_n = !front_sel;
  assign sram0_we_n = front_sel ? !wr_en : 1'b1;
  assign sram1_we_n = front_sel ? 1'b1 : !wr_en;

  assign sram0_data = (front_sel && wr_en) ? wr_data : 'z;
  assign sram1_data = (!front_sel && wr_en) ? wr_data : 'z;

  assign rd_data = front_sel ? sram1_data : sram0_data;

  always_comb begin
    a_one_writer : assert final (sram0_we_n || sram1_we_n)
      else $error("sram_mux: both SRAMs in write");
  end

endmodule

`default_nettype wire

//--- verilog/gfx_dbuf_top.sv
`default_nettype none

module gfx_dbuf_top (
  input  logic                     clk,
  input  logic                     rst_n,

  // wishbone slave
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  gfx_dbuf_pkg::wb_addr_t   wb_adr,
  input  gfx_dbuf_pkg::wb_data_t   wb_dat_w,
  output gfx_dbuf_pkg::wb_data_t   wb_dat_r,
  output logic                     wb_ack,

  output gfx_dbuf_pkg::sram_addr_t sram0_addr,
  inout  wire gfx_dbuf_pkg::sram_data_t sram0_data,
  output logic                     sram0_ce_n,
  output logic                     sram0_oe_n,
  output logic                     sram0_we_n,

  output gfx_dbuf_pkg::sram_addr_t sram1_addr,
  inout  wire gfx_dbuf_pkg::sram_data_t sram1_data,
  output logic                     sram1_ce_n,
  output logic                     sram1_oe_n,
  output logic                     sram1_we_n,

  output logic [3:0]               vga_r,
  output logic [3:0]               vga_g,
  output logic [3:0]               vga_b,
  output logic                     vga_hsync,
  output logic                     vga_vsync,
  output logic                     vga_de
);

  gfx_dbuf_pkg::xcoord_t    x;
  gfx_dbuf_pkg::ycoord_t    y;
  logic                     active;
  logic                     hsync;
  logic                     vsync;
  logic                     frame_start;

  gfx_dbuf_pkg::sram_addr_t rd_addr;
  gfx_dbuf_pkg::sram_data_t rd_data;
  gfx_dbuf_pkg::sram_addr_t wr_addr;
  gfx_dbuf_pkg::sram_data_t wr_data;
  logic                     wr_en;

  logic                     fill_start;
  logic                     fill_busy;
  gfx_dbuf_pkg::pixel_t     fill_color;
  gfx_dbuf_pkg::xcoord_t    x0;
  gfx_dbuf_pkg::xcoord_t    x1;
  gfx_dbuf_pkg::ycoord_t    y0;
  gfx_dbuf_pkg::ycoord_t    y1;
  logic                     front_sel;

  vga_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .x          (x),
    .y          (y),
    .active     (active),
    .hsync      (hsync),
    .vsync      (vsync),
    .frame_start(frame_start)
  );

  scanout u_scanout (
    .clk      (clk),
    .rst_n    (rst_n),
    .active   (active),
    .hsync    (hsync),
    .vsync    (vsync),
    .x        (x),
    .y        (y),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  fill_engine u_fill (
    .clk       (clk),
    .rst_n     (rst_n),
    .fill_start(fill_start),
    .fill_color(fill_color),
    .x0        (x0),
    .x1        (x1),
    .y0        (y0),
    .y1        (y1),
    .fill_busy (fill_busy),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  dbuf_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .fill_busy  (fill_busy),
    .frame_start(frame_start),
    .fill_start (fill_start),
    .fill_color (fill_color),
    .x0         (x0),
    .x1         (x1),
    .y0         (y0),
    .y1         (y1),
    .front_sel  (front_sel)
  );

  sram_mux u_mux (
    .front_sel (front_sel),
    .wr_en     (wr_en),
    .rd_addr   (rd_addr),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_data   (rd_data),
    .sram0_addr(sram0_addr),
    .sram1_addr(sram1_addr),
    .sram0_data(sram0_data),
    .sram1_data(sram1_data),
    .sram0_ce_n(sram0_ce_n),
    .sram0_oe_n(sram0_oe_n),
    .sram0_we_n(sram0_we_n),
    .sram1_ce_n(sram1_ce_n),
    .sram1_oe_n(sram1_oe_n),
    .sram1_we_n(sram1_we_n)
  );

endmodule

`default_nettype wire

//--- bench/sram_model.sv
`default_nettype none

module sram_model (
  input  gfx_dbuf_pkg::sram_addr_t      addr,
  inout  wire gfx_dbuf_pkg::sram_data_t data,
  input  logic                          ce_n,
  input  logic                          oe_n,
  input  logic                          we_n
);
  timeunit 1ns;
  timeprecision 1ps;

  // low 1k words cover the whole 40 x 16 scan
  localparam int DEPTH = 1024;

  gfx_dbuf_pkg::sram_data_t mem [0:DEPTH-1];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign data = (!ce_n && !oe_n && we_n) ? mem[addr[9:0]] : 'z;

  // write lands once address and data have settled after a change
  always @(addr or data or ce_n or we_n) begin
    #1;
    if (!ce_n && !we_n) begin
      mem[addr[9:0]] = data;
    end
  end

endmodule

`default_nettype wire

//--- bench/gfx_dbuf_checker.sv
`default_nettype none

module gfx_dbuf_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  gfx_dbuf_pkg::wb_addr_t wb_adr,
  input  gfx_dbuf_pkg::wb_data_t wb_dat_w,
  input  logic                   wb_ack,
  input  logic [3:0]             vga_r,
  input  logic [3:0]             vga_g,
  input  logic [3:0]             vga_b,
  input  logic                   vga_hsync,
  input  logic                   vga_vsync,
  input  logic                   vga_de,
  output int                     pixel_errors,
  output int                     sync_errors,
  output int                     pixels_checked
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HA       = gfx_dbuf_pkg::H_ACTIVE;
  localparam int VA       = gfx_dbuf_pkg::V_ACTIVE;
  localparam int FB_WORDS = HA * VA;

  // both frames, buffer 0 first
  gfx_dbuf_pkg::pixel_t fb [0:2*FB_WORDS-1];
  gfx_dbuf_pkg::pixel_t color;
  int                   front;
  logic                 swap_pending;
  int                   rx0;
  int                   rx1;
  int                   ry0;
  int                   ry1;
  int                   line;
  int                   de_run;
  int                   hs_run;
  int                   vs_run;
  int                   hs_period;
  int                   vs_period;
  logic                 hs_q;
  logic                 vs_q;
  logic                 de_q;
  logic                 hs_seen;
  logic                 vs_seen;

  // expected pixel after a fill, clipping comes from px and py staying on screen
  function automatic gfx_dbuf_pkg::pixel_t painted(input int px, input int py,
      input gfx_dbuf_pkg::pixel_t old, input gfx_dbuf_pkg::pixel_t c,
      input int x0, input int x1, input int y0, input int y1);
    if (px >= x0 && px <= x1 && py >= y0 && py <= y1) begin
      return c;
    end
    return old;
  endfunction

  task automatic apply_fill();
    int base;
    base = (1 - front) * FB_WORDS;
    for (int yy = 0; yy < VA; yy++) begin
      for (int xx = 0; xx < HA; xx++) begin
        fb[base + yy*HA + xx] = painted(xx, yy, fb[base + yy*HA + xx], color,
                                        rx0, rx1, ry0, ry1);
      end
    end
  endtask

  task automatic sync_error(input string what, input int got, input int want);
    sync_errors++;
    $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
  endtask

  task automatic check_pixel();
    gfx_dbuf_pkg::pixel_t shown;
    gfx_dbuf_pkg::pixel_t want;
    shown = {vga_r, vga_g, vga_b};
    if (vga_de) begin
      if (!de_q) begin
        de_run = 0;
      end
      if (de_run < HA && line < VA) begin
        want = fb[front*FB_WORDS + line*HA + de_run];
        pixels_checked++;
        if (shown !== want) begin
          pixel_errors++;
          $display("Error at %0t ns: pixel (%0d,%0d) of buffer %0d shows %h, expected %h",
                   $time, de_run, line, front, shown, want);
        end
      end
      de_run++;
    end else begin
      if (shown !== '0) begin
        pixel_errors++;
        $display("Error at %0t ns: colour %h outside the active area", $time, shown);
      end
      if (de_q) begin
        if (de_run != HA) sync_error("active pixels per line", de_run, HA);
        line++;
      end
    end
    de_q = vga_de;
  endtask

  task automatic check_sync();
    if (vga_hsync && !hs_q) begin
      if (hs_seen && hs_period != gfx_dbuf_pkg::H_TOTAL) begin
        sync_error("hsync period", hs_period, gfx_dbuf_pkg::H_TOTAL);
      end
      hs_seen   = 1'b1;
      hs_period = 0;
      hs_run    = 0;
    end
    hs_period++;
    if (vga_hsync) hs_run++;
    if (!vga_hsync && hs_q && hs_run != gfx_dbuf_pkg::H_SYNC) begin
      sync_error("hsync width", hs_run, gfx_dbuf_pkg::H_SYNC);
    end
    hs_q = vga_hsync;

    // frame boundary, the swap is already visible from here on
    if (vga_vsync && !vs_q) begin
      if (vs_seen && vs_period != gfx_dbuf_pkg::V_TOTAL * gfx_dbuf_pkg::H_TOTAL) begin
        sync_error("vsync period", vs_period, gfx_dbuf_pkg::V_TOTAL * gfx_dbuf_pkg::H_TOTAL);
      end
      if (line != VA) sync_error("active lines per frame", line, VA);
      vs_seen   = 1'b1;
      vs_period = 0;
      vs_run    = 0;
      line      = 0;
      if (swap_pending) begin
        front        = 1 - front;
        swap_pending = 1'b0;
      end
    end
    vs_period++;
    if (vga_vsync) vs_run++;
    if (!vga_vsync && vs_q && vs_run != gfx_dbuf_pkg::V_SYNC * gfx_dbuf_pkg::H_TOTAL) begin
      sync_error("vsync width", vs_run, gfx_dbuf_pkg::V_SYNC * gfx_dbuf_pkg::H_TOTAL);
    end
    vs_q = vga_vsync;
  endtask

  task automatic track_writes();
    if (wb_ack && wb_cyc && wb_stb && wb_we) begin
      case (wb_adr)
        gfx_dbuf_pkg::REG_CTRL: begin
          if (wb_dat_w[0]) apply_fill();
          if (wb_dat_w[1]) swap_pending = 1'b1;
        end
        gfx_dbuf_pkg::REG_COLOR: color = wb_dat_w[11:0];
        gfx_dbuf_pkg::REG_RECT_X: begin
          rx0 = wb_dat_w[7:0];
          rx1 = wb_dat_w[15:8];
        end
        gfx_dbuf_pkg::REG_RECT_Y: begin
          ry0 = wb_dat_w[7:0];
          ry1 = wb_dat_w[15:8];
        end
        default: ;
      endcase
    end
  endtask

  initial begin
    for (int i = 0; i < 2*FB_WORDS; i++) begin
      fb[i] = '0;
    end
    pixel_errors   = 0;
    sync_errors    = 0;
    pixels_checked = 0;
    color          = '0;
    rx0            = 0;
    rx1            = 0;
    ry0            = 0;
    ry1            = 0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      front        = 0;
      swap_pending = 1'b0;
      line         = 0;
      de_run       = 0;
      hs_run       = 0;
      vs_run       = 0;
      hs_period    = 0;
      vs_period    = 0;
      hs_q         = 1'b0;
      vs_q         = 1'b0;
      de_q         = 1'b0;
      hs_seen      = 1'b0;
      vs_seen      = 1'b0;
    end else begin
      check_pixel();
      // vsync before the bus, a request acked on the rise waits a frame
      check_sync();
      track_writes();
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_gfx_dbuf.sv
`default_nettype none

module tb_gfx_dbuf;
  timeunit 1ns;
  timeprecision 1ps;

  // about 25 frames of 640 cycles
  localparam int MAX_CYCLES = 16000;

  logic                          clk;
  logic                          rst_n;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  gfx_dbuf_pkg::wb_addr_t        wb_adr;
  gfx_dbuf_pkg::wb_data_t        wb_dat_w;
  gfx_dbuf_pkg::wb_data_t        wb_dat_r;
  logic                          wb_ack;
  gfx_dbuf_pkg::sram_addr_t      sram0_addr;
  gfx_dbuf_pkg::sram_addr_t      sram1_addr;
  wire gfx_dbuf_pkg::sram_data_t sram0_data;
  wire gfx_dbuf_pkg::sram_data_t sram1_data;
  logic                          sram0_ce_n;
  logic                          sram0_oe_n;
  logic                          sram0_we_n;
  logic                          sram1_ce_n;
  logic                          sram1_oe_n;
  logic                          sram1_we_n;
  logic [3:0]                    vga_r;
  logic [3:0]                    vga_g;
  logic [3:0]                    vga_b;
  logic                          vga_hsync;
  logic                          vga_vsync;
  logic                          vga_de;

  int     reg_errors;
  int     pixel_errors;
  int     sync_errors;
  int     pixels_checked;
  int     cycles;
  integer seed;
  logic   front_exp;

  always #50 clk = ~clk;

  gfx_dbuf_top i_gfx_dbuf_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .sram0_addr(sram0_addr),
    .sram0_data(sram0_data),
    .sram0_ce_n(sram0_ce_n),
    .sram0_oe_n(sram0_oe_n),
    .sram0_we_n(sram0_we_n),
    .sram1_addr(sram1_addr),
    .sram1_data(sram1_data),
    .sram1_ce_n(sram1_ce_n),
    .sram1_oe_n(sram1_oe_n),
    .sram1_we_n(sram1_we_n),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

  sram_model u_sram0 (
    .addr(sram0_addr),
    .data(sram0_data),
    .ce_n(sram0_ce_n),
    .oe_n(sram0_oe_n),
    .we_n(sram0_we_n)
  );

  sram_model u_sram1 (
    .addr(sram1_addr),
    .data(sram1_data),
    .ce_n(sram1_ce_n),
    .oe_n(sram1_oe_n),
    .we_n(sram1_we_n)
  );

  gfx_dbuf_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_ack        (wb_ack),
    .vga_r         (vga_r),
    .vga_g         (vga_g),
    .vga_b         (vga_b),
    .vga_hsync     (vga_hsync),
    .vga_vsync     (vga_vsync),
    .vga_de        (vga_de),
    .pixel_errors  (pixel_errors),
    .sync_errors   (sync_errors),
    .pixels_checked(pixels_checked)
  );

  task automatic write_reg(input gfx_dbuf_pkg::wb_addr_t adr, input gfx_dbuf_pkg::wb_data_t dat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic read_reg(input gfx_dbuf_pkg::wb_addr_t adr, output gfx_dbuf_pkg::wb_data_t dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    @(posedge clk);
    while (!wb_ack) @(posedge clk);
    dat = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic check_reg(input gfx_dbuf_pkg::wb_addr_t adr, input gfx_dbuf_pkg::wb_data_t want,
                           input string what);
    gfx_dbuf_pkg::wb_data_t got;
    read_reg(adr, got);
    if (got !== want) begin
      reg_errors++;
      $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic poll_idle();
    gfx_dbuf_pkg::wb_data_t status;
    read_reg(gfx_dbuf_pkg::REG_STATUS, status);
    while (status[0]) begin
      read_reg(gfx_dbuf_pkg::REG_STATUS, status);
    end
  endtask

  // returns just after the rising edge of vga_vsync
  task automatic next_frame();
    @(posedge clk);
    while (vga_vsync) @(posedge clk);
    while (!vga_vsync) @(posedge clk);
  endtask

  task automatic after_vsync();
    @(posedge clk);
    while (!vga_vsync) @(posedge clk);
    while (vga_vsync) @(posedge clk);
  endtask

  task automatic draw_rect(input int x0, input int x1, input int y0, input int y1,
                           input gfx_dbuf_pkg::pixel_t color);
    gfx_dbuf_pkg::wb_data_t rx;
    gfx_dbuf_pkg::wb_data_t ry;
    rx = {16'h0000, x1[7:0], x0[7:0]};
    ry = {16'h0000, y1[7:0], y0[7:0]};
    write_reg(gfx_dbuf_pkg::REG_COLOR, {20'h00000, color});
    write_reg(gfx_dbuf_pkg::REG_RECT_X, rx);
    write_reg(gfx_dbuf_pkg::REG_RECT_Y, ry);
    check_reg(gfx_dbuf_pkg::REG_COLOR, {20'h00000, color}, "color");
    check_reg(gfx_dbuf_pkg::REG_RECT_X, rx, "rect x");
    check_reg(gfx_dbuf_pkg::REG_RECT_Y, ry, "rect y");
    write_reg(gfx_dbuf_pkg::REG_CTRL, 32'h1);
  endtask

  task automatic request_swap();
    // early in the frame so the request cannot meet the frame start
    after_vsync();
    write_reg(gfx_dbuf_pkg::REG_CTRL, 32'h2);
    check_reg(gfx_dbuf_pkg::REG_STATUS, {29'd0, front_exp, 2'b10}, "status with swap pending");
    next_frame();
    front_exp = !front_exp;
    check_reg(gfx_dbuf_pkg::REG_STATUS, {29'd0, front_exp, 2'b00}, "status after swap");
  endtask

  task automatic finish_run(input logic timed_out);
    int total;
    if (pixels_checked == 0) begin
      $display("no displayed pixel was compared");
      reg_errors++;
    end
    total = reg_errors + pixel_errors + sync_errors;
    $display("errors: register %0d, pixel %0d, sync %0d", reg_errors, pixel_errors, sync_errors);
    if (total == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  initial begin
    int x0;
    int x1;
    int y0;
    int y1;
    gfx_dbuf_pkg::pixel_t color;
    clk        = 1'b0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    reg_errors = 0;
    cycles     = 0;
    front_exp  = 1'b0;
    seed       = 32'hc7bc09d9;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    if (wb_ack !== 1'b0) begin
      reg_errors++;
      $display("Error at %0t ns: wb_ack is high after reset", $time);
    end
    check_reg(gfx_dbuf_pkg::REG_STATUS, 32'h0, "status after reset");
    // first frame shows the cleared front buffer
    next_frame();

    // register readback and a fill hidden in the back buffer
    draw_rect(4, 19, 2, 8, 12'h5a3);
    check_reg(gfx_dbuf_pkg::REG_STATUS, {29'd0, front_exp, 2'b01}, "status while busy");
    check_reg(gfx_dbuf_pkg::REG_CTRL, 32'h0, "ctrl");
    check_reg(3'd7, 32'h0, "unmapped word");
    poll_idle();
    request_swap();

    for (int r = 0; r < 6; r++) begin
      if (r == 0) begin
        x0 = 0;
        x1 = gfx_dbuf_pkg::H_ACTIVE - 1;
        y0 = 0;
        y1 = gfx_dbuf_pkg::V_ACTIVE - 1;
      end else if (r == 1) begin
        x0 = 20;
        x1 = 5;
        y0 = 3;
        y1 = 9;
      end else begin
        // a little past the edges so clipping gets exercised
        x0 = {$random(seed)} % 36;
        x1 = {$random(seed)} % 36;
        y0 = {$random(seed)} % 14;
        y1 = {$random(seed)} % 14;
      end
      color = $random(seed);
      draw_rect(x0, x1, y0, y1, color);
      poll_idle();
      request_swap();
    end

    // let the last front frame go out in full
    next_frame();
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

//--- gfx_dbuf.f
verilog/gfx_dbuf_pkg.sv
verilog/vga_timing.sv
verilog/scanout.sv
verilog/fill_engine.sv
verilog/dbuf_regs.sv
verilog/sram_mux.sv
verilog/gfx_dbuf_top.sv
bench/sram_model.sv
bench/gfx_dbuf_checker.sv
bench/tb_gfx_dbuf.sv
